// File: pcs_rx_pkg.sv
// ----------------------------------------------------------------------
// PCS receive slice shared definitions
// Block widths, descrambler polynomial, header codes and error count
// ----------------------------------------------------------------------

package pcs_rx_pkg;

    // One 66-bit block is a 64-bit payload plus a 2-bit sync header
    localparam int word_wd = 64;
    localparam int hdr_wd  = 2;

    // Descrambler polynomial x^58 + x^39 + 1
    localparam int scr_len = 58;  // History length, outer tap
    localparam int scr_tap = 39;  // Inner tap

    // Legal sync header codes, anything else is a header error
    typedef enum logic [hdr_wd-1:0] {
        hdr_data = 2'b01,
        hdr_ctrl = 2'b10
    } sync_hdr_t;

    // Header error count, holds at all ones
    typedef logic [15:0] err_cnt_t;

endpackage

// File: pcs_blk_if.sv
// ----------------------------------------------------------------------
// Block stream bundle between receive stages
// ----------------------------------------------------------------------
`timescale 1ns/10ps

interface pcs_blk_if #(
    parameter int words = 1
);
    import pcs_rx_pkg::*;

    logic [words*word_wd-1:0] data;  // Payload, block 0 in the low bits
    logic [words*hdr_wd-1:0]  sync;  // One header per block
    logic                     valid;
    logic                     am;    // Alignment marker beat

    // Producing stage
    modport src (
        output data,
        output sync,
        output valid,
        output am
    );

    // Consuming stage
    modport dst (
        input data,
        input sync,
        input valid,
        input am
    );

endinterface

// File: descrambler.sv
// ----------------------------------------------------------------------
// Parallel self-synchronizing descrambler, x^58 + x^39 + 1
// Holds history across idle and AM beats, keeps sync and AM aligned
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module descrambler #(
    parameter int words = 1
) (
    input  logic                                    tclk,
    input  logic                                    reset,
    input  logic [words*pcs_rx_pkg::word_wd-1:0]    in_data,
    input  logic [words*pcs_rx_pkg::hdr_wd-1:0]     in_sync,
    input  logic                                    in_valid,
    input  logic                                    in_am,
    pcs_blk_if.src                                  blk
);
    import pcs_rx_pkg::*;

    localparam int beat_wd = words * word_wd;

    logic [scr_len-1:0]         hist;    // Last scrambled bits, msb is newest
    logic [beat_wd+scr_len-1:0] stream;  // History followed by this beat
    logic [beat_wd-1:0]         plain;
    logic                       take;

    // Only real data advances the descrambler
    assign take = in_valid & ~in_am;

    // Bit stream in arrival order, oldest bit at index 0
    assign stream = {in_data, hist};

    // Each plain bit is the received bit XOR the bits 39 and 58 earlier.
    // Bit i of the beat sits at stream[i+scr_len], so its taps fall back
    // into the history for the first bits and into the beat after that.
    always_comb begin
        for (int i = 0; i < beat_wd; i++) begin
            plain[i] = stream[i+scr_len]
                     ^ stream[i+scr_len-scr_tap]
                     ^ stream[i];
        end
    end

    // History and control state
    always_ff @(posedge tclk) begin
        if (reset) begin
            hist      <= '0;
            blk.valid <= 1'b0;
            blk.am    <= 1'b0;
        end else begin
            if (take) begin
                hist <= in_data[beat_wd-1 -: scr_len];  // Newest 58 bits
            end
            blk.valid <= take;
            blk.am    <= in_am;  // Flag follows the beat, valid ignored
        end
    end

    // Payload path
    always_ff @(posedge tclk) begin
        blk.data <= plain;
        blk.sync <= in_sync;  // Headers are never scrambled
    end

endmodule

// File: sync_header_check.sv
// ----------------------------------------------------------------------
// Sync header checker with per-block error flags
// Counts blocks whose header is neither data nor control
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module sync_header_check #(
    parameter int words = 1
) (
    input  logic                                    tclk,
    input  logic                                    reset,
    pcs_blk_if.dst                                  blk,
    output logic [words*pcs_rx_pkg::word_wd-1:0]    out_data,
    output logic [words*pcs_rx_pkg::hdr_wd-1:0]     out_sync,
    output logic                                    out_valid,
    output logic                                    out_am,
    output logic [words-1:0]                        hdr_err,
    output pcs_rx_pkg::err_cnt_t                    err_count
);
    import pcs_rx_pkg::*;

    localparam int nbad_wd = $clog2(words + 1);
    localparam int cnt_wd  = $bits(err_cnt_t);

    logic               counted;
    logic [words-1:0]   bad;
    logic [nbad_wd-1:0] nbad;       // Bad blocks in this beat
    logic [cnt_wd:0]    cnt_sum;    // One extra bit to catch overflow
    err_cnt_t           cnt_nxt;

    assign counted = blk.valid & ~blk.am;

    // Flag each block with an illegal header
    always_comb begin
        sync_hdr_t hdr;

        nbad = '0;
        for (int b = 0; b < words; b++) begin
            hdr    = sync_hdr_t'(blk.sync[b*hdr_wd +: hdr_wd]);
            bad[b] = counted && (hdr != hdr_data) && (hdr != hdr_ctrl);
            nbad   = nbad + nbad_wd'(bad[b]);
        end
    end

    // Saturating add
    assign cnt_sum = {1'b0, err_count} + (cnt_wd + 1)'(nbad);
    assign cnt_nxt = cnt_sum[cnt_wd] ? err_cnt_t'('1) : cnt_sum[cnt_wd-1:0];

    always_ff @(posedge tclk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_am    <= 1'b0;
            hdr_err   <= '0;
            err_count <= '0;
        end else begin
            out_valid <= blk.valid;
            out_am    <= blk.am;
            hdr_err   <= bad;       // Zero on idle and AM beats
            err_count <= cnt_nxt;   // Includes this beat already
        end
    end

    // Payload passes one stage
    always_ff @(posedge tclk) begin
        out_data <= blk.data;
        out_sync <= blk.sync;
    end

endmodule

// File: pcs_rx_top.sv
// ----------------------------------------------------------------------
// PCS receive slice, descrambler followed by sync header check
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module pcs_rx_top #(
    parameter int words = 1  // Blocks per beat, 1/2/4 for 25G/50G/100G
) (
    input  logic                                    tclk,
    input  logic                                    reset,
    input  logic [words*pcs_rx_pkg::word_wd-1:0]    rx_data_in,
    input  logic [words*pcs_rx_pkg::hdr_wd-1:0]     rx_sync_in,
    input  logic                                    rx_valid_in,
    input  logic                                    rx_am_in,
    output logic [words*pcs_rx_pkg::word_wd-1:0]    rx_data,
    output logic [words*pcs_rx_pkg::hdr_wd-1:0]     rx_sync,
    output logic                                    rx_valid,
    output logic                                    rx_am,
    output logic [words-1:0]                        hdr_err,
    output pcs_rx_pkg::err_cnt_t                    err_count
);

    // Descrambled stream between the two stages
    pcs_blk_if #(.words(words)) dsc_blk ();

    descrambler #(
        .words    (words)
    ) u_descrambler (
        .tclk     (tclk),
        .reset    (reset),
        .in_data  (rx_data_in),
        .in_sync  (rx_sync_in),
        .in_valid (rx_valid_in),
        .in_am    (rx_am_in),
        .blk      (dsc_blk.src)
    );

    sync_header_check #(
        .words     (words)
    ) u_sync_header_check (
        .tclk      (tclk),
        .reset     (reset),
        .blk       (dsc_blk.dst),
        .out_data  (rx_data),
        .out_sync  (rx_sync),
        .out_valid (rx_valid),
        .out_am    (rx_am),
        .hdr_err   (hdr_err),
        .err_count (err_count)
    );

endmodule

// File: tb_pcs_rx.sv
// ----------------------------------------------------------------------
// Testbench for the PCS receive slice
// Scrambles random traffic, checks descrambled data and header errors
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_pcs_rx;
    import pcs_rx_pkg::*;

    localparam int words     = 2;
    localparam int beat_wd   = words * word_wd;
    localparam int sync_wd   = words * hdr_wd;
    localparam int n_reset   = 16;
    localparam int n_beats   = 1200;
    localparam int n_idle0   = 20;                      // All-zero beats after reset
    localparam int cyc_limit = n_reset + n_beats + 50;

    typedef struct packed {
        int                 due;    // Cycle at which the output is checked
        logic [beat_wd-1:0] data;
        logic [sync_wd-1:0] sync;
        logic               valid;
        logic               am;
        logic [words-1:0]   err;
        err_cnt_t           cnt;
    } exp_beat_t;

    logic               tclk;
    logic               reset;
    logic [beat_wd-1:0] rx_data_in;
    logic [sync_wd-1:0] rx_sync_in;
    logic               rx_valid_in;
    logic               rx_am_in;
    logic [beat_wd-1:0] rx_data;
    logic [sync_wd-1:0] rx_sync;
    logic               rx_valid;
    logic               rx_am;
    logic [words-1:0]   hdr_err;
    err_cnt_t           err_count;

    logic [31:0]        lfsr = 32'd85;
    logic [scr_len-1:0] scr_hist = '0;   // Scrambler state, oldest bit at 0
    err_cnt_t           ref_cnt = '0;
    exp_beat_t          exp_q[$];
    int                 cyc = 0;
    int                 n_checked = 0;

    pcs_rx_top #(.words(words)) DUT (
        .tclk        (tclk),
        .reset       (reset),
        .rx_data_in  (rx_data_in),
        .rx_sync_in  (rx_sync_in),
        .rx_valid_in (rx_valid_in),
        .rx_am_in    (rx_am_in),
        .rx_data     (rx_data),
        .rx_sync     (rx_sync),
        .rx_valid    (rx_valid),
        .rx_am       (rx_am),
        .hdr_err     (hdr_err),
        .err_count   (err_count)
    );

    always #4 tclk = ~tclk;

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'hD000_0001;
        end
        return b;
    endfunction

    function automatic logic [beat_wd-1:0] rand_bits(input int n);
        logic [beat_wd-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    // Self-synchronizing scrambler, s[i] = p[i] ^ s[i-39] ^ s[i-58]
    function automatic logic [beat_wd-1:0] scramble(input logic [scr_len-1:0] h,
                                                    input logic [beat_wd-1:0] p);
        logic [scr_len+beat_wd-1:0] s;
        s = '0;
        s[scr_len-1:0] = h;
        for (int i = 0; i < beat_wd; i++) begin
            s[scr_len+i] = p[i] ^ s[scr_len+i-scr_tap] ^ s[i];
        end
        return s[scr_len+beat_wd-1:scr_len];
    endfunction

    // Expected output beat for one input beat
    function automatic exp_beat_t ref_beat(input logic [beat_wd-1:0] p,
                                           input logic [sync_wd-1:0] sh,
                                           input logic v, input logic a,
                                           input err_cnt_t cnt_in);
        exp_beat_t         e;
        logic [hdr_wd-1:0] h;
        int                nbad;
        e       = '0;
        e.data  = p;
        e.sync  = sh;
        e.valid = v & ~a;
        e.am    = a;
        nbad    = 0;
        for (int b = 0; b < words; b++) begin
            h = sh[b*hdr_wd +: hdr_wd];
            if (e.valid && h != hdr_data && h != hdr_ctrl) begin
                e.err[b] = 1'b1;
                nbad++;
            end
        end
        if (int'(cnt_in) + nbad > int'(err_cnt_t'('1))) begin
            e.cnt = '1;  // Saturate
        end else begin
            e.cnt = cnt_in + err_cnt_t'(nbad);
        end
        return e;
    endfunction

    task automatic check_data(input string name, input logic [beat_wd-1:0] exp,
                              input logic [beat_wd-1:0] act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Payload mismatch");
        end
    endtask

    task automatic check_sync(input string name, input sync_hdr_t exp, input sync_hdr_t act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Sync header mismatch");
        end
    endtask

    task automatic check_count(input string name, input err_cnt_t exp, input err_cnt_t act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Error count mismatch");
        end
    endtask

    task automatic check_bits(input string name, input logic [words-1:0] exp,
                              input logic [words-1:0] act);
        if (act !== exp) begin
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "Flag mismatch");
        end
    endtask

    // Cycle count and run limit
    always @(posedge tclk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display(">>> FAIL");
            $fatal(1, "Timeout, the test did not finish within %0d cycles", cyc_limit);
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge tclk) begin : compare
        exp_beat_t e;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            check_bits("rx_valid", words'(e.valid), words'(rx_valid));
            check_bits("rx_am", words'(e.am), words'(rx_am));
            check_bits("hdr_err", e.err, hdr_err);
            check_count("err_count", e.cnt, err_count);
            for (int b = 0; b < words; b++) begin
                check_sync("rx_sync", sync_hdr_t'(e.sync[b*hdr_wd +: hdr_wd]),
                           sync_hdr_t'(rx_sync[b*hdr_wd +: hdr_wd]));
            end
            if (e.valid) begin
                check_data("rx_data", e.data, rx_data);  // Payload only on data beats
            end
            n_checked++;
        end
    end

    initial begin : stimulus
        logic [beat_wd-1:0] plain;
        logic [beat_wd-1:0] scr;
        logic [sync_wd-1:0] sh;
        logic [hdr_wd-1:0]  h;
        logic               v;
        logic               a;
        logic               bad;
        logic               hb;
        exp_beat_t          e;

        tclk        = 1'b0;
        reset       = 1'b1;
        rx_data_in  = '0;
        rx_sync_in  = '0;
        rx_valid_in = 1'b0;
        rx_am_in    = 1'b0;
        repeat (n_reset) @(posedge tclk);
        #1;
        reset = 1'b0;

        for (int k = 0; k < n_beats; k++) begin
            @(posedge tclk);
            #1;
            if (k < n_idle0) begin
                plain = '0;
                sh    = '0;
                v     = 1'b0;
                a     = 1'b0;
            end else begin
                v = (rand_bits(3) != 0);           // About one gap in eight
                a = (rand_bits(4) == 0);
                if (a) begin
                    v = lfsr_bit();                // Valid is a don't care on AM
                end
                plain = rand_bits(beat_wd);
                for (int b = 0; b < words; b++) begin
                    bad = (rand_bits(3) == 0);
                    hb  = lfsr_bit();
                    h   = bad ? {hb, hb} : {hb, ~hb};  // 00/11 or 01/10
                    sh[b*hdr_wd +: hdr_wd] = h;
                end
            end

            if (v && !a) begin
                scr      = scramble(scr_hist, plain);
                scr_hist = scr[beat_wd-1 -: scr_len];
            end else begin
                scr = plain;
            end
            rx_data_in  = scr;
            rx_sync_in  = sh;
            rx_valid_in = v;
            rx_am_in    = a;

            e       = ref_beat(plain, sh, v, a, ref_cnt);
            ref_cnt = e.cnt;
            e.due   = cyc + 2;
            exp_q.push_back(e);
        end

        @(posedge tclk);
        #1;
        rx_valid_in = 1'b0;
        rx_am_in    = 1'b0;
        wait (n_checked == n_beats);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: src.f
pcs_rx_pkg.sv
pcs_blk_if.sv
descrambler.sv
sync_header_check.sv
pcs_rx_top.sv
tb_pcs_rx.sv

// File: Bender.yml
package:
  name: pcs_rx

sources:
  - pcs_rx_pkg.sv
  - pcs_blk_if.sv
  - descrambler.sv
  - sync_header_check.sv
  - pcs_rx_top.sv
  - target: simulation
    files:
      - tb_pcs_rx.sv
